/* all.f */
rtl/pr_slot_pkg.sv
rtl/pr_freeze_ctrl.sv
rtl/axis_freeze_bridge.sv
rtl/afu_incr.sv
rtl/pr_slot_top.sv
sim/pr_slot_checker.sv
sim/pr_slot_tb.sv

/* rtl/afu_incr.sv */
// Example accelerator for the slot. A single pipeline stage adds AFU_INCR
// to every data word, keeps tlast and tags each beat with a running packet
// number. afu_rst is a synchronous soft reset from the slot control.

`timescale 1ns/1ps

module afu_incr (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  afu_rst,
   input  pr_slot_pkg::rx_beat_t in_data,
   input  logic                  in_valid,
   output logic                  in_ready,
   output pr_slot_pkg::tx_beat_t out_data,
   output logic                  out_valid,
   input  logic                  out_ready
);

   logic [pr_slot_pkg::PKT_NUM_W-1:0] pkt_num;
   logic [pr_slot_pkg::PKT_NUM_W-1:0] pkt_num_tag;
   logic                              in_fire;
   logic                              pkt_done;

   assign in_ready = !afu_rst && (!out_valid || out_ready);   // Stage free or emptying
   assign in_fire  = in_valid && in_ready;
   assign pkt_done = out_valid && out_ready && out_data.tlast;

   // A beat entering as the previous packet closes belongs to the next one
   assign pkt_num_tag = pkt_done ? pkt_num + 1'b1 : pkt_num;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         pkt_num   <= '0;
      end else if (afu_rst) begin
         out_valid <= 1'b0;   // Flush the stage
         pkt_num   <= '0;
      end else begin
         if (!out_valid || out_ready) out_valid <= in_valid;
         if (pkt_done)                pkt_num   <= pkt_num + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         out_data.tdata   <= in_data.tdata + pr_slot_pkg::AFU_INCR;
         out_data.tlast   <= in_data.tlast;
         out_data.pkt_num <= pkt_num_tag;
      end
   end

endmodule : afu_incr

/* rtl/axis_freeze_bridge.sv */
// Packet-aware skid buffer with a freeze mode for the slot boundary.
// Two entries with a registered in_ready give one cycle of latency at full
// throughput. Freeze is entered only between packets; while frozen every
// input beat is accepted, discarded and reported on drop.

`timescale 1ns/1ps

module axis_freeze_bridge #(
   parameter type payload_t = pr_slot_pkg::rx_beat_t   // Needs a tlast member
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     freeze_req,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready,
   output logic     frozen,
   output logic     drop
);

   payload_t skid_data;
   logic     skid_valid;
   logic     in_mid;          // Last accepted beat was not tlast
   logic     out_mid;         // Last output transfer was not tlast
   logic     in_fire;
   logic     pass_fire;
   logic     out_fire;
   logic     main_free;
   logic     enter_freeze;
   logic     frozen_next;
   logic     skid_valid_next;
   logic     in_mid_next;
   logic     in_ready_next;

   assign in_fire   = in_valid && in_ready;
   assign pass_fire = in_fire && !frozen;
   assign out_fire  = out_valid && out_ready;
   assign main_free = !out_valid || out_ready;
   assign drop      = in_fire && frozen;           // Discarded beat

   // ------------------------------------------------------------------------
   // Freeze control
   // ------------------------------------------------------------------------
   // Nothing held and the last beat out closed its packet
   assign enter_freeze = freeze_req && !frozen && !out_valid && !skid_valid &&
                         !out_mid && !pass_fire;
   assign frozen_next  = frozen ? freeze_req : enter_freeze;

   assign in_mid_next  = pass_fire ? !in_data.tlast : in_mid;

   always_comb begin
      skid_valid_next = skid_valid;
      if (main_free)      skid_valid_next = 1'b0;  // Skid drains into main
      else if (pass_fire) skid_valid_next = 1'b1;  // Main stalled, park the beat
   end

   // A pending freeze stops intake at the next packet boundary so the
   // buffer can drain; once frozen the input is always accepted
   assign in_ready_next = frozen_next ||
                          (!skid_valid_next && !(freeze_req && !in_mid_next));

   // ------------------------------------------------------------------------
   // Control state
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         in_ready   <= 1'b0;
         frozen     <= 1'b0;
         in_mid     <= 1'b0;
         out_mid    <= 1'b0;
      end else begin
         if (main_free) out_valid <= skid_valid || pass_fire;
         skid_valid <= skid_valid_next;
         in_ready   <= in_ready_next;
         frozen     <= frozen_next;
         in_mid     <= in_mid_next;
         if (out_fire) out_mid <= !out_data.tlast;
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (main_free) begin
         if (skid_valid)     out_data <= skid_data;
         else if (pass_fire) out_data <= in_data;
      end else if (pass_fire) begin
         skid_data <= in_data;
      end
   end

endmodule : axis_freeze_bridge

/* rtl/pr_freeze_ctrl.sv */
// Slot control. Serves the AXI4-Lite register block, runs the freeze
// sequence over both bridges, holds the AFU in soft reset after a release
// and counts host beats discarded while frozen.

`timescale 1ns/1ps

module pr_freeze_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  pr_slot_pkg::axil_req_t axil_req,
   output pr_slot_pkg::axil_rsp_t axil_rsp,
   input  logic                   rx_frozen,
   input  logic                   tx_frozen,
   input  logic                   rx_drop,
   output logic                   freeze_req,
   output logic                   afu_rst
);

   typedef enum logic [1:0] {
      ST_RUN,
      ST_FREEZING,
      ST_FROZEN,
      ST_AFU_RST
   } state_t;

   state_t                                 state;
   logic [pr_slot_pkg::RST_CNT_W-1:0]      rst_cnt;
   logic                                   ctrl_freeze;   // CTRL bit 0
   logic [pr_slot_pkg::AXIL_DATA_W-1:0]    drop_cnt;
   logic                                   both_frozen;
   logic                                   release_done;

   logic                                   awready_q;
   logic                                   arready_q;
   logic                                   bvalid_q;
   logic                                   rvalid_q;
   logic [1:0]                             bresp_q;
   logic [1:0]                             rresp_q;
   logic [pr_slot_pkg::AXIL_DATA_W-1:0]    rdata_q;
   logic [pr_slot_pkg::AXIL_DATA_W-1:0]    rd_mux;
   logic [1:0]                             rd_resp;
   logic                                   wr_fire;
   logic                                   rd_fire;

   function automatic logic addr_in_map(input logic [pr_slot_pkg::AXIL_ADDR_W-1:0] addr);
      return (addr == pr_slot_pkg::REG_CTRL)     || (addr == pr_slot_pkg::REG_STATUS) ||
             (addr == pr_slot_pkg::REG_DROP_CNT) || (addr == pr_slot_pkg::REG_ID);
   endfunction

   // ------------------------------------------------------------------------
   // Freeze sequencing
   // ------------------------------------------------------------------------
   assign both_frozen  = rx_frozen && tx_frozen;
   assign freeze_req   = (state != ST_RUN);           // Held through the AFU reset
   assign afu_rst      = (state == ST_AFU_RST);
   assign release_done = afu_rst && (rst_cnt == '0);  // Last soft reset cycle

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_RUN;
         rst_cnt <= '0;
      end else begin
         unique case (state)
            ST_RUN:      if (ctrl_freeze) state <= ST_FREEZING;
            ST_FREEZING: if (both_frozen) state <= ST_FROZEN;   // Bridges reach a boundary
            ST_FROZEN: begin
               if (!ctrl_freeze) begin
                  state   <= ST_AFU_RST;
                  rst_cnt <= pr_slot_pkg::RST_CNT_LOAD;
               end
            end
            ST_AFU_RST: begin
               if (release_done) state <= ST_RUN;
               else              rst_cnt <= rst_cnt - 1'b1;
            end
            default:     state <= ST_RUN;
         endcase
      end
   end

   // Saturating count of discarded host beats, cleared as freeze_req drops
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         drop_cnt <= '0;
      end else if (release_done) begin
         drop_cnt <= '0;
      end else if (rx_drop && freeze_req && (drop_cnt != '1)) begin
         drop_cnt <= drop_cnt + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // AXI4-Lite register block
   // ------------------------------------------------------------------------
   assign wr_fire = awready_q && axil_req.awvalid && axil_req.wvalid;
   assign rd_fire = arready_q && axil_req.arvalid;

   always_comb begin
      rd_mux  = '0;
      rd_resp = pr_slot_pkg::RESP_OKAY;
      case (axil_req.araddr)
         pr_slot_pkg::REG_CTRL:     rd_mux = {31'b0, ctrl_freeze};
         pr_slot_pkg::REG_STATUS:   rd_mux = {30'b0, afu_rst, both_frozen};
         pr_slot_pkg::REG_DROP_CNT: rd_mux = drop_cnt;
         pr_slot_pkg::REG_ID:       rd_mux = pr_slot_pkg::SLOT_ID;
         default:                   rd_resp = pr_slot_pkg::RESP_SLVERR;  // Reads zero
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready_q   <= 1'b0;
         arready_q   <= 1'b0;
         bvalid_q    <= 1'b0;
         rvalid_q    <= 1'b0;
         ctrl_freeze <= 1'b0;
      end else begin
         // One cycle ready pulses, none while a response is outstanding
         awready_q <= !awready_q && !bvalid_q && axil_req.awvalid && axil_req.wvalid;
         arready_q <= !arready_q && !rvalid_q && axil_req.arvalid;

         if (wr_fire) begin
            bvalid_q <= 1'b1;
            if (axil_req.awaddr == pr_slot_pkg::REG_CTRL) ctrl_freeze <= axil_req.wdata[0];
         end else if (bvalid_q && axil_req.bready) begin
            bvalid_q <= 1'b0;
         end

         if (rd_fire)                            rvalid_q <= 1'b1;
         else if (rvalid_q && axil_req.rready)   rvalid_q <= 1'b0;
      end
   end

   // Response payloads, held until accepted
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         bresp_q <= addr_in_map(axil_req.awaddr) ? pr_slot_pkg::RESP_OKAY
                                                 : pr_slot_pkg::RESP_SLVERR;
      end
      if (rd_fire) begin
         rdata_q <= rd_mux;
         rresp_q <= rd_resp;
      end
   end

   always_comb begin
      axil_rsp.awready = awready_q;
      axil_rsp.wready  = awready_q;   // Address and data taken together
      axil_rsp.bvalid  = bvalid_q;
      axil_rsp.bresp   = bresp_q;
      axil_rsp.arready = arready_q;
      axil_rsp.rvalid  = rvalid_q;
      axil_rsp.rdata   = rdata_q;
      axil_rsp.rresp   = rresp_q;
   end

endmodule : pr_freeze_ctrl

/* rtl/pr_slot_pkg.sv */
// Shared definitions for the partial-reconfiguration slot.
// Holds the stream beat structs, the AXI4-Lite register map and the
// slot constants. RTL and testbench refer to these by scoped names.

package pr_slot_pkg;

   // ------------------------------------------------------------------------
   // Stream beats
   // ------------------------------------------------------------------------
   localparam int DATA_W    = 64;
   localparam int PKT_NUM_W = 8;

   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic              tlast;
   } rx_beat_t;                                 // Host to AFU, 65 bits

   typedef struct packed {
      logic [DATA_W-1:0]    tdata;
      logic                 tlast;
      logic [PKT_NUM_W-1:0] pkt_num;
   } tx_beat_t;                                 // AFU to host, 73 bits

   // ------------------------------------------------------------------------
   // Slot constants
   // ------------------------------------------------------------------------
   localparam logic [DATA_W-1:0] AFU_INCR       = 64'h1;
   localparam int                AFU_RST_CYCLES = 4;
   localparam int                RST_CNT_W      = $clog2(AFU_RST_CYCLES + 1);
   localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(AFU_RST_CYCLES - 1);

   // ------------------------------------------------------------------------
   // AXI4-Lite register port
   // ------------------------------------------------------------------------
   localparam int AXIL_ADDR_W = 8;
   localparam int AXIL_DATA_W = 32;

   localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 8'h00;  // Bit 0 freeze request
   localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 8'h04;  // Bit 0 frozen, bit 1 AFU reset
   localparam logic [AXIL_ADDR_W-1:0] REG_DROP_CNT = 8'h08;
   localparam logic [AXIL_ADDR_W-1:0] REG_ID       = 8'h0C;

   localparam logic [AXIL_DATA_W-1:0] SLOT_ID = 32'h5052_5301;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef struct packed {
      logic                   awvalid;
      logic [AXIL_ADDR_W-1:0] awaddr;
      logic                   wvalid;
      logic [AXIL_DATA_W-1:0] wdata;
      logic                   bready;
      logic                   arvalid;
      logic [AXIL_ADDR_W-1:0] araddr;
      logic                   rready;
   } axil_req_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      logic [1:0]             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
   } axil_rsp_t;

endpackage : pr_slot_pkg

/* rtl/pr_slot_top.sv */
// Top level of the partial-reconfiguration slot. Host packets pass through
// the receive bridge, the AFU and the transmit bridge; the control module
// drives freeze and soft reset and is reached over AXI4-Lite.

`timescale 1ns/1ps

module pr_slot_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  pr_slot_pkg::axil_req_t axil_req,
   output pr_slot_pkg::axil_rsp_t axil_rsp,
   input  pr_slot_pkg::rx_beat_t  host_rx_data,
   input  logic                   host_rx_valid,
   output logic                   host_rx_ready,
   output pr_slot_pkg::tx_beat_t  host_tx_data,
   output logic                   host_tx_valid,
   input  logic                   host_tx_ready
);

   pr_slot_pkg::rx_beat_t afu_rx_data;       // Receive bridge to AFU
   logic                  afu_rx_valid;
   logic                  afu_rx_ready;
   pr_slot_pkg::tx_beat_t afu_tx_data;       // AFU to transmit bridge
   logic                  afu_tx_valid;
   logic                  afu_tx_ready;
   logic                  freeze_req;
   logic                  afu_rst;
   logic                  rx_frozen;
   logic                  tx_frozen;
   logic                  rx_drop;

   pr_freeze_ctrl i_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .rx_frozen  (rx_frozen),
      .tx_frozen  (tx_frozen),
      .rx_drop    (rx_drop),
      .freeze_req (freeze_req),
      .afu_rst    (afu_rst)
   );

   axis_freeze_bridge #(.payload_t(pr_slot_pkg::rx_beat_t)) rx_bridge (
      .clk        (clk),
      .rst_n      (rst_n),
      .freeze_req (freeze_req),
      .in_data    (host_rx_data),
      .in_valid   (host_rx_valid),
      .in_ready   (host_rx_ready),
      .out_data   (afu_rx_data),
      .out_valid  (afu_rx_valid),
      .out_ready  (afu_rx_ready),
      .frozen     (rx_frozen),
      .drop       (rx_drop)       // Host beats lost to the freeze
   );

   afu_incr i_afu (
      .clk        (clk),
      .rst_n      (rst_n),
      .afu_rst    (afu_rst),
      .in_data    (afu_rx_data),
      .in_valid   (afu_rx_valid),
      .in_ready   (afu_rx_ready),
      .out_data   (afu_tx_data),
      .out_valid  (afu_tx_valid),
      .out_ready  (afu_tx_ready)
   );

   // AFU side discards are not counted
   axis_freeze_bridge #(.payload_t(pr_slot_pkg::tx_beat_t)) tx_bridge (
      .clk        (clk),
      .rst_n      (rst_n),
      .freeze_req (freeze_req),
      .in_data    (afu_tx_data),
      .in_valid   (afu_tx_valid),
      .in_ready   (afu_tx_ready),
      .out_data   (host_tx_data),
      .out_valid  (host_tx_valid),
      .out_ready  (host_tx_ready),
      .frozen     (tx_frozen),
      .drop       ()
   );

endmodule : pr_slot_top

/* run.sh */
#!/bin/sh
# Build the slot testbench with Verilator and run it from the project root.
# Exit status is zero only when the simulation prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pr_slot_tb \
   -o pr_slot_sim &&
./obj_dir/pr_slot_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

/* sim/pr_slot_checker.sv */
// Concurrent assertions on the slot boundary, bound into pr_slot_top.
// Covers the AXI4-Lite response hold rules and the host_tx stream rules.

`timescale 1ns/1ps

module pr_slot_checker (
   input logic                   clk,
   input logic                   rst_n,
   input pr_slot_pkg::axil_req_t axil_req,
   input pr_slot_pkg::axil_rsp_t axil_rsp,
   input logic                   host_tx_valid,
   input logic                   host_tx_ready,
   input logic                   rx_frozen,
   input logic                   tx_frozen
);

   bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
      else $error("rvalid dropped before rready");

   // Stream beat may not be withdrawn
   tx_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      host_tx_valid && !host_tx_ready |=> host_tx_valid)
      else $error("host_tx valid dropped before ready");

   tx_idle_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      rx_frozen && tx_frozen |-> !host_tx_valid)  // STATUS bit 0 set
      else $error("host_tx valid high while slot reports frozen");

endmodule : pr_slot_checker

bind pr_slot_top pr_slot_checker i_checker (
   .clk           (clk),
   .rst_n         (rst_n),
   .axil_req      (axil_req),
   .axil_rsp      (axil_rsp),
   .host_tx_valid (host_tx_valid),
   .host_tx_ready (host_tx_ready),
   .rx_frozen     (rx_frozen),
   .tx_frozen     (tx_frozen)
);

/* sim/pr_slot_tb.sv */
// Testbench for the partial-reconfiguration slot.
// Drives the AXI4-Lite register port and the host streams of pr_slot_top,
// predicts every host_tx beat from the sent host_rx beats and runs the
// register, traffic, freeze, discard and release tests in sequence.

`timescale 1ns/1ps

module pr_slot_tb;

   localparam int TIMEOUT_CYCLES = 20000;

   logic                   clk = 1'b0;
   logic                   rst_n;
   pr_slot_pkg::axil_req_t axil_req;
   pr_slot_pkg::axil_rsp_t axil_rsp;
   pr_slot_pkg::rx_beat_t  host_rx_data;
   logic                   host_rx_valid;
   logic                   host_rx_ready;
   pr_slot_pkg::tx_beat_t  host_tx_data;
   logic                   host_tx_valid;
   logic                   host_tx_ready;

   pr_slot_pkg::rx_beat_t  sent_q[$];        // Beats still owed on host_tx
   pr_slot_pkg::tx_beat_t  exp_beat;
   logic [7:0]             exp_pkt = '0;
   string                  test_name = "reset";
   int                     err_cnt = 0;
   int                     err_at_start = 0;
   int                     tests_run = 0;
   int                     tests_failed = 0;
   int                     cycle_cnt = 0;
   int                     beats_sent = 0;
   int                     tails_out = 0;    // tlast beats seen on host_tx
   bit                     stall_en = 1'b0;
   bit                     quiet = 1'b0;     // Slot frozen, host_tx must idle

   always #4 clk = ~clk;

   pr_slot_top i_pr_slot_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .axil_req      (axil_req),
      .axil_rsp      (axil_rsp),
      .host_rx_data  (host_rx_data),
      .host_rx_valid (host_rx_valid),
      .host_rx_ready (host_rx_ready),
      .host_tx_data  (host_tx_data),
      .host_tx_valid (host_tx_valid),
      .host_tx_ready (host_tx_ready)
   );

   // -------------------------------------------------------------------------
   // Reference model and checks
   // -------------------------------------------------------------------------
   function automatic pr_slot_pkg::tx_beat_t ref_beat(input pr_slot_pkg::rx_beat_t sent,
                                                      input logic [7:0] num);
      pr_slot_pkg::tx_beat_t b;
      b.tdata   = sent.tdata + pr_slot_pkg::AFU_INCR;
      b.tlast   = sent.tlast;
      b.pkt_num = num;
      return b;
   endfunction

   task automatic compare_value(input string what, input logic [72:0] expected,
                                input logic [72:0] actual);
      assert (expected === actual) else begin
         $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic confirm(input bit cond, input string msg);
      assert (cond) else begin
         $display("%s: %s", test_name, msg);
         err_cnt++;
      end
   endtask

   // Sampled mid cycle, a transfer here lands on the next rising edge
   always @(negedge clk) begin
      if (rst_n && host_tx_valid && host_tx_ready) begin
         if (host_tx_data.tlast) tails_out++;
         if (sent_q.size() == 0) begin
            confirm(1'b0, "beat on host_tx with nothing outstanding");
         end else begin
            exp_beat = ref_beat(sent_q.pop_front(), exp_pkt);
            compare_value("host_tx beat", exp_beat, host_tx_data);
            if (exp_beat.tlast) exp_pkt++;
         end
      end
      if (rst_n && quiet) confirm(!host_tx_valid, "host_tx valid raised while frozen");
   end

   // -------------------------------------------------------------------------
   // Drivers
   // -------------------------------------------------------------------------
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   always @(posedge clk) begin
      #1;
      host_tx_ready = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
   end

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      axil_req.awaddr  = addr;
      axil_req.wdata   = data;
      axil_req.awvalid = 1'b1;
      axil_req.wvalid  = 1'b1;
      while (!axil_rsp.awready) step();
      step();                                // Address and data taken
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      while (!axil_rsp.bvalid) step();
      repeat ($urandom_range(0, 2)) step();  // Response waits on bready
      resp = axil_rsp.bresp;
      axil_req.bready  = 1'b1;
      step();
      axil_req.bready  = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      while (!axil_rsp.arready) step();
      step();
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid) step();
      repeat ($urandom_range(0, 2)) step();  // Read data waits on rready
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      axil_req.rready  = 1'b1;
      step();
      axil_req.rready  = 1'b0;
   endtask

   task automatic verify_reg(input string what, input logic [7:0] addr,
                             input logic [31:0] exp_data, input logic [1:0] exp_resp);
      logic [31:0] data;
      logic [1:0]  resp;
      read_reg(addr, data, resp);
      compare_value({what, " data"}, exp_data, data);
      compare_value({what, " resp"}, exp_resp, resp);
   endtask

   // One packet of random words, queued for checking when keep is set
   task automatic send_packet(input int len, input bit keep);
      pr_slot_pkg::rx_beat_t beat;
      for (int i = 0; i < len; i++) begin
         beat.tdata    = {$urandom, $urandom};
         beat.tlast    = (i == len - 1);
         host_rx_data  = beat;
         host_rx_valid = 1'b1;
         while (!host_rx_ready) step();
         if (keep) sent_q.push_back(beat);
         beats_sent++;
         step();
      end
      host_rx_valid = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name    = name;
      err_at_start = err_cnt;
   endtask

   task automatic finish_test();
      tests_run++;
      if (err_cnt == err_at_start) begin
         $display("test %s: passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed", test_name);
      end
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      logic [31:0] status;
      logic [1:0]  resp;
      int          n_drop;
      int          tails_before;
      int          beats_start;
      void'($urandom(32'h62c4));
      rst_n         = 1'b0;
      axil_req      = '0;
      host_rx_data  = '0;
      host_rx_valid = 1'b0;
      host_tx_ready = 1'b0;
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      step();

      start_test("reset_regs");
      verify_reg("ID", pr_slot_pkg::REG_ID, pr_slot_pkg::SLOT_ID, pr_slot_pkg::RESP_OKAY);
      verify_reg("CTRL", pr_slot_pkg::REG_CTRL, '0, pr_slot_pkg::RESP_OKAY);
      verify_reg("STATUS", pr_slot_pkg::REG_STATUS, '0, pr_slot_pkg::RESP_OKAY);
      verify_reg("DROP_CNT", pr_slot_pkg::REG_DROP_CNT, '0, pr_slot_pkg::RESP_OKAY);
      verify_reg("unmapped read", 8'h10, '0, pr_slot_pkg::RESP_SLVERR);
      write_reg(8'h10, 32'hFFFF_FFFF, resp);
      compare_value("unmapped write resp", pr_slot_pkg::RESP_SLVERR, resp);
      verify_reg("CTRL after unmapped write", pr_slot_pkg::REG_CTRL, '0,
                 pr_slot_pkg::RESP_OKAY);
      finish_test();

      start_test("traffic");
      stall_en = 1'b1;
      for (int p = 0; p < 30; p++) send_packet($urandom_range(1, 8), 1'b1);
      while (sent_q.size() != 0) step();
      finish_test();

      // Freeze request lands two beats into an eight beat packet
      start_test("freeze_mid_packet");
      tails_before = tails_out;
      beats_start  = beats_sent;
      fork
         send_packet(8, 1'b1);
         begin
            while (beats_sent < beats_start + 2) step();
            write_reg(pr_slot_pkg::REG_CTRL, 32'h1, resp);
            compare_value("CTRL write resp", pr_slot_pkg::RESP_OKAY, resp);
         end
      join
      status = '0;
      while (!status[0]) begin
         read_reg(pr_slot_pkg::REG_STATUS, status, resp);
         if (status[0]) confirm(tails_out > tails_before, "frozen before packet tail left");
      end
      compare_value("beats outstanding", 0, sent_q.size());
      quiet = 1'b1;
      repeat (20) step();
      finish_test();

      start_test("discard_frozen");
      n_drop = $urandom_range(3, 10);
      send_packet(n_drop, 1'b0);               // Never expected back
      step();
      verify_reg("DROP_CNT", pr_slot_pkg::REG_DROP_CNT, n_drop, pr_slot_pkg::RESP_OKAY);
      finish_test();

      start_test("release");
      write_reg(pr_slot_pkg::REG_CTRL, 32'h0, resp);
      compare_value("CTRL write resp", pr_slot_pkg::RESP_OKAY, resp);
      status = 32'h1;
      while (status[0]) read_reg(pr_slot_pkg::REG_STATUS, status, resp);
      quiet = 1'b0;
      verify_reg("DROP_CNT", pr_slot_pkg::REG_DROP_CNT, '0, pr_slot_pkg::RESP_OKAY);
      exp_pkt = '0;                           // AFU soft reset restarts numbering
      for (int p = 0; p < 4; p++) send_packet($urandom_range(1, 8), 1'b1);
      while (sent_q.size() != 0) step();
      finish_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule : pr_slot_tb
